//--- common/periph_macros.svh
/*
 * Peripheral subsystem address map, register offsets and sizes
 */

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Block windows, bits 13..12 pick the block
`define PERIPH_WIN_MASK 32'hFFFF_F000
`define SOC_CTRL_BASE   32'h0000_0000
`define GPIO_BASE       32'h0000_1000
`define TIMER_BASE      32'h0000_2000
`define IRQ_BASE        32'h0000_3000

`define GPIO_WIDTH  8
`define NUM_IRQ_SRC 12
`define EXT_IRQ_NUM 2

`define SOC_EXIT_VALID_OFS 12'h000
`define SOC_EXIT_VALUE_OFS 12'h004
`define SOC_BOOT_SEL_OFS   12'h008
`define SOC_SCRATCH_OFS    12'h00C

`define GPIO_IN_OFS         12'h000
`define GPIO_OUT_OFS        12'h004
`define GPIO_OE_OFS         12'h008
`define GPIO_INTR_EN_OFS    12'h00C
`define GPIO_INTR_STATE_OFS 12'h010

`define TMR_CTRL_OFS     12'h000
`define TMR_PRESCALE_OFS 12'h004
`define TMR_COUNT_OFS    12'h008
`define TMR_COMPARE_OFS  12'h00C

`define IRQ_PENDING_OFS 12'h000
`define IRQ_ENABLE_OFS  12'h004
`define IRQ_CLAIM_OFS   12'h008
`define IRQ_MSIP_OFS    12'h00C

`endif

//--- common/periph_pkg.sv
/*
 * Peripheral subsystem types
 * Upstream and register bus structs, word typedefs and bridge FSM states
 */

`default_nettype none

package periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Interrupt source ID, 0 is reserved for none
  typedef logic [3:0] irq_id_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } obi_rsp_t;

  // Offset inside the 4 KiB block window
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    data_t       wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  typedef enum logic {
    BR_IDLE,
    BR_RESP
  } bridge_state_e;

endpackage : periph_pkg

`default_nettype wire

//--- rtl/periph_bridge.sv
/*
 * Peripheral bridge
 * Grants one upstream access at a time and forwards it to one register block
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_bridge
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  obi_req_t obi_req_i,
  output obi_rsp_t obi_rsp_o,

  output reg_req_t soc_req_o,
  output reg_req_t gpio_req_o,
  output reg_req_t timer_req_o,
  output reg_req_t irq_req_o,

  input  reg_rsp_t soc_rsp_i,
  input  reg_rsp_t gpio_rsp_i,
  input  reg_rsp_t timer_rsp_i,
  input  reg_rsp_t irq_rsp_i
);

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          grant;
  logic [3:0]    blk_sel;
  reg_req_t      req_base;
  reg_rsp_t      blk_rsp;
  data_t         rdata_q;
  logic          err_q;

  assign grant = (state_q == BR_IDLE) && obi_req_i.req;

  // One-hot block select, nothing selected for out-of-map addresses
  always_comb begin
    case (obi_req_i.addr & `PERIPH_WIN_MASK)
      `SOC_CTRL_BASE: blk_sel = 4'b0001;
      `GPIO_BASE:     blk_sel = 4'b0010;
      `TIMER_BASE:    blk_sel = 4'b0100;
      `IRQ_BASE:      blk_sel = 4'b1000;
      default:        blk_sel = 4'b0000;
    endcase
  end

  always_comb begin
    req_base.valid = 1'b0;
    req_base.write = obi_req_i.we;
    req_base.addr  = obi_req_i.addr[11:0];
    req_base.wdata = obi_req_i.wdata;

    soc_req_o         = req_base;
    soc_req_o.valid   = grant & blk_sel[0];
    gpio_req_o        = req_base;
    gpio_req_o.valid  = grant & blk_sel[1];
    timer_req_o       = req_base;
    timer_req_o.valid = grant & blk_sel[2];
    irq_req_o         = req_base;
    irq_req_o.valid   = grant & blk_sel[3];
  end

  always_comb begin
    case (blk_sel)
      4'b0001: blk_rsp = soc_rsp_i;
      4'b0010: blk_rsp = gpio_rsp_i;
      4'b0100: blk_rsp = timer_rsp_i;
      4'b1000: blk_rsp = irq_rsp_i;
      default: blk_rsp = '{ready: 1'b1, rdata: '0, error: 1'b1};
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: if (grant) state_d = BR_RESP;
      BR_RESP: state_d = BR_IDLE;
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A missing ready counts as an error too
  always_ff @(posedge clk_i) begin
    if (grant) begin
      err_q   <= blk_rsp.error | ~blk_rsp.ready;
      rdata_q <= (blk_rsp.error | ~blk_rsp.ready) ? '0 : blk_rsp.rdata;
    end
  end

  assign obi_rsp_o.gnt    = grant;
  assign obi_rsp_o.rvalid = (state_q == BR_RESP);
  assign obi_rsp_o.rdata  = rdata_q;
  assign obi_rsp_o.err    = err_q;

endmodule : periph_bridge

`default_nettype wire

//--- soc_ctrl/soc_ctrl.sv
/*
 * SoC control block
 * Exit status for the simulator, boot select readback and a scratch word
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module soc_ctrl
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     boot_select_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     exit_valid_o,
  output data_t    exit_value_o
);

  logic  exit_valid_q;
  data_t exit_value_q;
  data_t scratch_q;
  logic  wr_en;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        `SOC_EXIT_VALID_OFS: exit_valid_q <= reg_req_i.wdata[0];
        `SOC_EXIT_VALUE_OFS: exit_value_q <= reg_req_i.wdata;
        `SOC_SCRATCH_OFS:    scratch_q    <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      `SOC_EXIT_VALID_OFS: reg_rsp_o.rdata = data_t'(exit_valid_q);
      `SOC_EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      `SOC_BOOT_SEL_OFS:   reg_rsp_o.rdata = data_t'(boot_select_i);
      `SOC_SCRATCH_OFS:    reg_rsp_o.rdata = scratch_q;
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

//--- gpio/gpio.sv
/*
 * GPIO block
 * Synchronized inputs, output and enable registers, rising-edge interrupts
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module gpio
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  reg_req_t               reg_req_i,
  output reg_rsp_t               reg_rsp_o,
  input  logic [`GPIO_WIDTH-1:0] gpio_i,
  output logic [`GPIO_WIDTH-1:0] gpio_o,
  output logic [`GPIO_WIDTH-1:0] gpio_en_o,
  output logic [`GPIO_WIDTH-1:0] intr_o
);

  logic [`GPIO_WIDTH-1:0] sync_q1;
  logic [`GPIO_WIDTH-1:0] data_in_q;
  logic [`GPIO_WIDTH-1:0] data_in_prev_q;
  logic [`GPIO_WIDTH-1:0] out_q;
  logic [`GPIO_WIDTH-1:0] oe_q;
  logic [`GPIO_WIDTH-1:0] intr_en_q;
  logic [`GPIO_WIDTH-1:0] intr_state_q;
  logic [`GPIO_WIDTH-1:0] rise;
  logic [`GPIO_WIDTH-1:0] wdata;
  logic [`GPIO_WIDTH-1:0] state_clr;
  logic                   wr_en;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign wdata = reg_req_i.wdata[`GPIO_WIDTH-1:0];
  assign rise  = data_in_q & ~data_in_prev_q;

  // Write one to clear
  assign state_clr = (wr_en && reg_req_i.addr == `GPIO_INTR_STATE_OFS) ? wdata : '0;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1        <= '0;
      data_in_q      <= '0;
      data_in_prev_q <= '0;
    end else begin
      sync_q1        <= gpio_i;
      data_in_q      <= sync_q1;
      data_in_prev_q <= data_in_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q        <= '0;
      oe_q         <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      if (wr_en) begin
        case (reg_req_i.addr)
          `GPIO_OUT_OFS:     out_q     <= wdata;
          `GPIO_OE_OFS:      oe_q      <= wdata;
          `GPIO_INTR_EN_OFS: intr_en_q <= wdata;
          default: ;
        endcase
      end
      // A new edge wins over a clear in the same cycle
      intr_state_q <= (intr_state_q & ~state_clr) | rise;
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      `GPIO_IN_OFS:         reg_rsp_o.rdata = data_t'(data_in_q);
      `GPIO_OUT_OFS:        reg_rsp_o.rdata = data_t'(out_q);
      `GPIO_OE_OFS:         reg_rsp_o.rdata = data_t'(oe_q);
      `GPIO_INTR_EN_OFS:    reg_rsp_o.rdata = data_t'(intr_en_q);
      `GPIO_INTR_STATE_OFS: reg_rsp_o.rdata = data_t'(intr_state_q);
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = intr_state_q & intr_en_q;

endmodule : gpio

`default_nettype wire

//--- timer/periph_timer.sv
/*
 * Timer block
 * Prescaled up-counter with a registered compare interrupt
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_timer
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     irq_timer_o
);

  logic  enable_q;
  data_t prescale_q;
  data_t presc_cnt_q;
  data_t count_q;
  data_t compare_q;
  logic  irq_q;
  logic  tick;
  logic  wr_en;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign tick  = enable_q && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      count_q     <= '0;
      compare_q   <= '1;
      irq_q       <= 1'b0;
    end else begin
      // Prescaler wraps after PRESCALE+1 enabled cycles
      if (tick) begin
        presc_cnt_q <= '0;
        count_q     <= count_q + 32'd1;
      end else if (enable_q) begin
        presc_cnt_q <= presc_cnt_q + 32'd1;
      end
      irq_q <= enable_q && (count_q >= compare_q);
      if (wr_en) begin
        case (reg_req_i.addr)
          `TMR_CTRL_OFS: enable_q <= reg_req_i.wdata[0];
          `TMR_PRESCALE_OFS: begin
            prescale_q  <= reg_req_i.wdata;
            presc_cnt_q <= '0;
          end
          `TMR_COUNT_OFS: begin
            count_q <= reg_req_i.wdata;
            irq_q   <= 1'b0;
          end
          `TMR_COMPARE_OFS: begin
            compare_q <= reg_req_i.wdata;
            irq_q     <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      `TMR_CTRL_OFS:     reg_rsp_o.rdata = data_t'(enable_q);
      `TMR_PRESCALE_OFS: reg_rsp_o.rdata = prescale_q;
      `TMR_COUNT_OFS:    reg_rsp_o.rdata = count_q;
      `TMR_COMPARE_OFS:  reg_rsp_o.rdata = compare_q;
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  assign irq_timer_o = irq_q;

endmodule : periph_timer

`default_nettype wire

//--- rtl/irq_ctrl.sv
/*
 * Interrupt controller
 * Pending latch, enable mask, claim by lowest ID and a software interrupt bit
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module irq_ctrl
  import periph_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  reg_req_t                reg_req_i,
  output reg_rsp_t                reg_rsp_o,
  input  logic [`NUM_IRQ_SRC-1:0] intr_src_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  logic [`NUM_IRQ_SRC-1:0] src_q;
  logic [`NUM_IRQ_SRC-1:0] pending_q;
  logic [`NUM_IRQ_SRC-1:0] enable_q;
  logic [`NUM_IRQ_SRC-1:0] pend_set;
  logic [`NUM_IRQ_SRC-1:0] pend_clr;
  logic                    msip_q;
  logic                    irq_q;
  logic                    wr_en;
  logic                    claim_rd;
  irq_id_t                 claim_id;

  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign claim_rd = reg_req_i.valid & ~reg_req_i.write & (reg_req_i.addr == `IRQ_CLAIM_OFS);

  // Latch on a source going high, so a held source is not claimed twice
  // ID 0 never pends
  assign pend_set = intr_src_i & ~src_q & ~`NUM_IRQ_SRC'(1);

  // Lowest pending and enabled ID
  always_comb begin
    claim_id = '0;
    for (int i = `NUM_IRQ_SRC - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) claim_id = irq_id_t'(i);
    end
  end

  always_comb begin
    pend_clr = '0;
    if (claim_rd && claim_id != '0) pend_clr[claim_id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      src_q     <= intr_src_i;
      pending_q <= (pending_q & ~pend_clr) | pend_set;
      irq_q     <= |(pending_q & enable_q);
      if (wr_en && reg_req_i.addr == `IRQ_ENABLE_OFS) enable_q <= reg_req_i.wdata[`NUM_IRQ_SRC-1:0];
      if (wr_en && reg_req_i.addr == `IRQ_MSIP_OFS) msip_q <= reg_req_i.wdata[0];
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      `IRQ_PENDING_OFS: reg_rsp_o.rdata = data_t'(pending_q);
      `IRQ_ENABLE_OFS:  reg_rsp_o.rdata = data_t'(enable_q);
      `IRQ_CLAIM_OFS:   reg_rsp_o.rdata = data_t'(claim_id);
      `IRQ_MSIP_OFS:    reg_rsp_o.rdata = data_t'(msip_q);
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule : irq_ctrl

`default_nettype wire

//--- rtl/peripheral_subsystem.sv
/*
 * Peripheral subsystem top
 * Bridge, SoC control, GPIO, timer and interrupt controller
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    boot_select_i,

  input  obi_req_t                obi_req_i,
  output obi_rsp_t                obi_rsp_o,

  output logic                    exit_valid_o,
  output data_t                   exit_value_o,

  input  logic [`GPIO_WIDTH-1:0]  gpio_i,
  output logic [`GPIO_WIDTH-1:0]  gpio_o,
  output logic [`GPIO_WIDTH-1:0]  gpio_en_o,

  input  logic [`EXT_IRQ_NUM-1:0] ext_irq_i,
  output logic                    irq_o,
  output logic                    msip_o,
  output logic                    irq_timer_o
);

  reg_req_t soc_req;
  reg_req_t gpio_req;
  reg_req_t timer_req;
  reg_req_t irq_req;
  reg_rsp_t soc_rsp;
  reg_rsp_t gpio_rsp;
  reg_rsp_t timer_rsp;
  reg_rsp_t irq_rsp;

  logic [`GPIO_WIDTH-1:0]  gpio_intr;
  logic [`NUM_IRQ_SRC-1:0] intr_vector;

  // ID 0 is reserved, then timer, GPIO pins and external lines
  assign intr_vector = {ext_irq_i, gpio_intr, irq_timer_o, 1'b0};

  periph_bridge periph_bridge_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i,
    .obi_rsp_o,
    .soc_req_o  (soc_req),
    .gpio_req_o (gpio_req),
    .timer_req_o(timer_req),
    .irq_req_o  (irq_req),
    .soc_rsp_i  (soc_rsp),
    .gpio_rsp_i (gpio_rsp),
    .timer_rsp_i(timer_rsp),
    .irq_rsp_i  (irq_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .boot_select_i,
    .reg_req_i(soc_req),
    .reg_rsp_o(soc_rsp),
    .exit_valid_o,
    .exit_value_o
  );

  gpio gpio_i0 (
    .clk_i,
    .arst_n_i,
    .reg_req_i(gpio_req),
    .reg_rsp_o(gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o   (gpio_intr)
  );

  periph_timer periph_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(timer_req),
    .reg_rsp_o(timer_rsp),
    .irq_timer_o
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i (irq_req),
    .reg_rsp_o (irq_rsp),
    .intr_src_i(intr_vector),
    .irq_o,
    .msip_o
  );

endmodule : peripheral_subsystem

`default_nettype wire

//--- tests/tb_peripheral_subsystem.sv
/*
 * Testbench for the peripheral subsystem
 * Drives the upstream port and pins, checks every register block
 */

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  // Five tests of at most about 200 cycles each
  localparam int WATCHDOG_NS = 5 * 200 * CLK_PERIOD;

  logic                    clk;
  logic                    arst_n;
  logic                    boot_select;
  obi_req_t                obi_req;
  obi_rsp_t                obi_rsp;
  logic                    exit_valid;
  data_t                   exit_value;
  logic [`GPIO_WIDTH-1:0]  gpio_in;
  logic [`GPIO_WIDTH-1:0]  gpio_out;
  logic [`GPIO_WIDTH-1:0]  gpio_oe;
  logic [`EXT_IRQ_NUM-1:0] ext_irq;
  logic                    irq;
  logic                    msip;
  logic                    irq_timer;
  logic                    gnt;
  logic                    rvalid;

  int                      seed = 32'ha305_8939;
  int                      error_count = 0;
  int                      tests_failed = 0;
  data_t                   scratch_model;
  data_t                   exit_model;

  peripheral_subsystem i_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .boot_select_i(boot_select),
    .obi_req_i    (obi_req),
    .obi_rsp_o    (obi_rsp),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_oe),
    .ext_irq_i    (ext_irq),
    .irq_o        (irq),
    .msip_o       (msip),
    .irq_timer_o  (irq_timer)
  );

  assign gnt    = obi_rsp.gnt;
  assign rvalid = obi_rsp.rvalid;

  // One outstanding access, response exactly one cycle after grant
  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid == $past(gnt))
    else begin
      error_count = error_count + 1;
      $display("Protocol error at %0t ns: rvalid does not follow gnt by one cycle", $time);
    end

  no_gnt_while_pending: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid |-> !gnt)
    else begin
      error_count = error_count + 1;
      $display("Protocol error at %0t ns: gnt raised while a response is pending", $time);
    end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_word(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      error_count = error_count + 1;
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // Drive on the rising edge, sample gnt and rvalid mid-cycle
  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    @(posedge clk);
    obi_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!gnt) @(negedge clk);
    @(posedge clk);
    obi_req <= '0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    rdata = obi_rsp.rdata;
    err   = obi_rsp.err;
  endtask

  // Second request is presented while the first response is still pending
  task automatic read_back_to_back(input addr_t addr_a, input addr_t addr_b,
                                   output data_t rdata_a, output logic err_a,
                                   output data_t rdata_b, output logic err_b);
    @(posedge clk);
    obi_req <= '{req: 1'b1, we: 1'b0, addr: addr_a, wdata: '0};
    @(negedge clk);
    while (!gnt) @(negedge clk);
    @(posedge clk);
    obi_req <= '{req: 1'b1, we: 1'b0, addr: addr_b, wdata: '0};
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    rdata_a = obi_rsp.rdata;
    err_a   = obi_rsp.err;
    while (!gnt) @(negedge clk);
    @(posedge clk);
    obi_req <= '0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    rdata_b = obi_rsp.rdata;
    err_b   = obi_rsp.err;
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata);
    data_t rdata;
    logic  err;
    bus_access(1'b1, addr, wdata, rdata, err);
    compare_word("write err", data_t'(err), '0);
  endtask

  task automatic read_expect(input string name, input addr_t addr, input data_t exp);
    data_t rdata;
    logic  err;
    bus_access(1'b0, addr, '0, rdata, err);
    compare_word({name, " err"}, data_t'(err), '0);
    compare_word(name, rdata, exp);
  endtask

  function automatic logic watch_level(input int sel);
    case (sel)
      0:       return irq_timer;
      1:       return irq;
      default: return msip;
    endcase
  endfunction

  task automatic wait_level(input string name, input int sel, input logic level,
                            input int max_cycles);
    int n;
    n = 0;
    while (watch_level(sel) !== level && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    assert (watch_level(sel) === level) else begin
      error_count = error_count + 1;
      $display("Timed out after %0d cycles waiting for %s to become %0b", max_cycles, name,
               level);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", num, name, error_count - errs_before);
    end
  endtask

  task automatic test_soc_ctrl();
    int errs;
    errs = error_count;
    compare_word("gnt", data_t'(gnt), '0);
    compare_word("rvalid", data_t'(rvalid), '0);
    compare_word("exit_valid_o", data_t'(exit_valid), '0);
    compare_word("gpio_o", data_t'(gpio_out), '0);
    compare_word("gpio_en_o", data_t'(gpio_oe), '0);
    compare_word("irq_o", data_t'(irq), '0);
    compare_word("msip_o", data_t'(msip), '0);
    compare_word("irq_timer_o", data_t'(irq_timer), '0);
    scratch_model = $random(seed);
    exit_model    = $random(seed);
    write_reg(`SOC_CTRL_BASE + `SOC_SCRATCH_OFS, scratch_model);
    write_reg(`SOC_CTRL_BASE + `SOC_EXIT_VALUE_OFS, exit_model);
    read_expect("SCRATCH", `SOC_CTRL_BASE + `SOC_SCRATCH_OFS, scratch_model);
    read_expect("EXIT_VALUE", `SOC_CTRL_BASE + `SOC_EXIT_VALUE_OFS, exit_model);
    read_expect("BOOT_SEL", `SOC_CTRL_BASE + `SOC_BOOT_SEL_OFS, 32'd1);
    @(posedge clk);
    boot_select <= 1'b0;
    read_expect("BOOT_SEL", `SOC_CTRL_BASE + `SOC_BOOT_SEL_OFS, 32'd0);
    write_reg(`SOC_CTRL_BASE + `SOC_EXIT_VALID_OFS, 32'd1);
    compare_word("exit_valid_o", data_t'(exit_valid), 32'd1);
    compare_word("exit_value_o", exit_value, exit_model);
    report_test(1, "soc_ctrl", errs);
  endtask

  task automatic test_gpio();
    int                     errs;
    logic [`GPIO_WIDTH-1:0] out_model;
    logic [`GPIO_WIDTH-1:0] oe_model;
    logic [`GPIO_WIDTH-1:0] pattern;
    errs      = error_count;
    out_model = 8'($random(seed));
    oe_model  = 8'($random(seed));
    pattern   = 8'($random(seed));
    write_reg(`GPIO_BASE + `GPIO_OUT_OFS, data_t'(out_model));
    write_reg(`GPIO_BASE + `GPIO_OE_OFS, data_t'(oe_model));
    compare_word("gpio_o", data_t'(gpio_out), data_t'(out_model));
    compare_word("gpio_en_o", data_t'(gpio_oe), data_t'(oe_model));
    @(posedge clk);
    gpio_in <= pattern;
    repeat (4) @(posedge clk);
    read_expect("IN", `GPIO_BASE + `GPIO_IN_OFS, data_t'(pattern));
    // Quiet pins, then clear edges left over from the pattern
    @(posedge clk);
    gpio_in <= '0;
    repeat (4) @(posedge clk);
    write_reg(`GPIO_BASE + `GPIO_INTR_STATE_OFS, 32'h0000_00FF);
    write_reg(`GPIO_BASE + `GPIO_INTR_EN_OFS, 32'h0000_00FF);
    read_expect("INTR_STATE", `GPIO_BASE + `GPIO_INTR_STATE_OFS, '0);
    @(posedge clk);
    gpio_in <= 8'h40;
    repeat (4) @(posedge clk);
    read_expect("INTR_STATE", `GPIO_BASE + `GPIO_INTR_STATE_OFS, 32'h0000_0040);
    write_reg(`GPIO_BASE + `GPIO_INTR_STATE_OFS, 32'h0000_0040);
    read_expect("INTR_STATE", `GPIO_BASE + `GPIO_INTR_STATE_OFS, '0);
    report_test(2, "gpio", errs);
  endtask

  task automatic test_timer();
    int    errs;
    data_t count;
    logic  err;
    errs = error_count;
    write_reg(`TIMER_BASE + `TMR_PRESCALE_OFS, 32'd1);
    write_reg(`TIMER_BASE + `TMR_COMPARE_OFS, 32'd20);
    write_reg(`TIMER_BASE + `TMR_CTRL_OFS, 32'd1);
    for (int i = 0; i < 3; i++) begin
      bus_access(1'b0, `TIMER_BASE + `TMR_COUNT_OFS, '0, count, err);
      compare_word("COUNT below 20", data_t'(count < 32'd20), 32'd1);
      compare_word("irq_timer_o", data_t'(irq_timer), '0);
    end
    wait_level("irq_timer_o", 0, 1'b1, 50);
    write_reg(`TIMER_BASE + `TMR_COMPARE_OFS, 32'hFFFF_FFFF);
    compare_word("irq_timer_o", data_t'(irq_timer), '0);
    write_reg(`TIMER_BASE + `TMR_CTRL_OFS, '0);
    report_test(3, "timer", errs);
  endtask

  task automatic test_irq();
    int errs;
    errs = error_count;
    // Pin 3 is source 5, ext_irq_i bit 0 is source 10
    @(posedge clk);
    gpio_in <= 8'h48;
    ext_irq <= 2'b01;
    repeat (5) @(posedge clk);
    write_reg(`IRQ_BASE + `IRQ_ENABLE_OFS, 32'h0000_0420);
    wait_level("irq_o", 1, 1'b1, 5);
    read_expect("CLAIM", `IRQ_BASE + `IRQ_CLAIM_OFS, 32'd5);
    read_expect("CLAIM", `IRQ_BASE + `IRQ_CLAIM_OFS, 32'd10);
    read_expect("CLAIM", `IRQ_BASE + `IRQ_CLAIM_OFS, '0);
    wait_level("irq_o", 1, 1'b0, 5);
    write_reg(`IRQ_BASE + `IRQ_MSIP_OFS, 32'd1);
    compare_word("msip_o", data_t'(msip), 32'd1);
    report_test(4, "irq_ctrl", errs);
  endtask

  task automatic test_decode_err();
    int    errs;
    data_t rdata;
    logic  err;
    data_t rdata_b;
    logic  err_b;
    errs = error_count;
    bus_access(1'b0, 32'h0001_0000, '0, rdata, err);
    compare_word("out-of-map read err", data_t'(err), 32'd1);
    compare_word("out-of-map read rdata", rdata, '0);
    bus_access(1'b1, 32'h0001_0000, 32'hDEAD_BEEF, rdata, err);
    compare_word("out-of-map write err", data_t'(err), 32'd1);
    bus_access(1'b0, `GPIO_BASE + 12'h020, '0, rdata, err);
    compare_word("undefined offset err", data_t'(err), 32'd1);
    compare_word("undefined offset rdata", rdata, '0);
    // Valid read queued right behind an out-of-map read
    read_back_to_back(32'h0001_0000, `SOC_CTRL_BASE + `SOC_SCRATCH_OFS,
                      rdata, err, rdata_b, err_b);
    compare_word("queued out-of-map err", data_t'(err), 32'd1);
    compare_word("queued out-of-map rdata", rdata, '0);
    compare_word("SCRATCH err", data_t'(err_b), '0);
    compare_word("SCRATCH", rdata_b, scratch_model);
    report_test(5, "decode errors", errs);
  endtask

  initial begin
    arst_n      = 1'b0;
    boot_select = 1'b1;
    obi_req     = '0;
    gpio_in     = '0;
    ext_irq     = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    test_soc_ctrl();
    test_gpio();
    test_timer();
    test_irq();
    test_decode_err();
    $display("Tests run: 5, tests failed: %0d, errors: %0d", tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, a test did not finish", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule : tb_peripheral_subsystem

`default_nettype wire

//--- project.f
+incdir+common
common/periph_pkg.sv
rtl/periph_bridge.sv
soc_ctrl/soc_ctrl.sv
gpio/gpio.sv
timer/periph_timer.sv
rtl/irq_ctrl.sv
rtl/peripheral_subsystem.sv
tests/tb_peripheral_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
verilator --binary --timing --assert -f project.f \
  --top-module tb_peripheral_subsystem -o tb_sim || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -qF "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
